/* source/fpgame_consts.svh */
`ifndef FPGAME_CONSTS_SVH
`define FPGAME_CONSTS_SVH

// ==============================
// Display timing
// ==============================
`define FPGAME_H_ACTIVE    16   // Visible pixels per line
`define FPGAME_H_TOTAL     24   // Cycles per line, sync included
`define FPGAME_V_ACTIVE    8    // Visible lines per frame
`define FPGAME_V_TOTAL     12   // Lines per frame, vblank included

// ==============================
// Video memory sizes
// ==============================
// Tiles are 2x2 pixels, so the map is 32 pixels wide
`define FPGAME_MAP_COLS    16
`define FPGAME_MAP_ROWS    4
`define FPGAME_PAL_SIZE    16

// Host write queue, also the number of host credits
`define FPGAME_QUEUE_DEPTH 8

`endif

/* source/video_pkg.sv */
`default_nettype none

package video_pkg;

    // Display side widths
    typedef logic [23:0] color_t;   // R in [23:16], G in [15:8], B in [7:0]
    typedef logic [3:0]  pal_idx_t; // One of 16 palette entries
    typedef logic [4:0]  hcount_t;  // Cycle within a line
    typedef logic [3:0]  vcount_t;  // Line within a frame
    typedef logic [4:0]  scroll_t;  // Pixel offset, wraps with the map width

    // Frame phases
    typedef enum logic [1:0] {
        ACTIVE,
        VBLANK_COMMIT,  // Queued host writes drain here
        VBLANK_PREP     // Row 0 gets rendered
    } frame_state_t;

endpackage : video_pkg

`default_nettype wire

/* source/vram_pkg.sv */
`default_nettype none

package vram_pkg;

    // Host address map:
    //   0x00-0x3F  tile map, row-major, 16 entries per row
    //   0x40-0x4F  palette
    //   0x80       background scroll
    typedef logic [7:0]  wr_addr_t;
    typedef logic [23:0] wr_data_t;

    typedef enum logic [1:0] {
        TGT_MAP,
        TGT_PAL,
        TGT_SCROLL,
        TGT_NONE    // Unmapped address, dropped on commit
    } wr_target_t;

endpackage : vram_pkg

`default_nettype wire

/* source/vram_wr_if.sv */
`timescale 1ns/100ps
`default_nettype none

// Committed video memory writes, one per cycle with valid high
interface vram_wr_if;

    logic                 valid;
    vram_pkg::wr_target_t target;
    vram_pkg::wr_addr_t   addr;
    vram_pkg::wr_data_t   data;

    // Write queue side
    modport drain (
        output valid,
        output target,
        output addr,
        output data
    );

    // Tile map and scroll holder
    modport map_sink (
        input valid,
        input target,
        input addr,
        input data
    );

    // Palette holder
    modport pal_sink (
        input valid,
        input target,
        input addr,
        input data
    );

endinterface : vram_wr_if

`default_nettype wire

/* source/frame_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fpgame_consts.svh"

module frame_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    output logic               commit_en,
    output logic               render_start,
    output video_pkg::vcount_t render_row,
    output logic               row_swap,
    output logic               line_active,
    output logic               hsync,
    output logic               vblank,
    output video_pkg::hcount_t hcount
);

    localparam video_pkg::hcount_t H_ACTIVE = video_pkg::hcount_t'(`FPGAME_H_ACTIVE);
    localparam video_pkg::hcount_t H_LAST   = video_pkg::hcount_t'(`FPGAME_H_TOTAL - 1);
    localparam video_pkg::vcount_t V_ACTIVE = video_pkg::vcount_t'(`FPGAME_V_ACTIVE);
    localparam video_pkg::vcount_t V_LAST   = video_pkg::vcount_t'(`FPGAME_V_TOTAL - 1);

    video_pkg::hcount_t      hcnt;
    video_pkg::vcount_t      vcnt;
    video_pkg::frame_state_t state;
    logic                    line_end;
    logic                    render_line;   // Next line is a visible row

    assign line_end = (hcnt == H_LAST);

    // ==============================
    // Timing counters
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hcnt <= '0;
            vcnt <= V_LAST;     // Line before row 0, so row 0 is ready for frame 0
        end else if (line_end) begin
            hcnt <= '0;
            vcnt <= (vcnt == V_LAST) ? '0 : vcnt + 1'b1;
        end else begin
            hcnt <= hcnt + 1'b1;
        end
    end

    // ==============================
    // Frame FSM
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= video_pkg::VBLANK_PREP;
        end else if (line_end) begin
            case (state)
                video_pkg::ACTIVE: begin
                    if (vcnt == V_ACTIVE - 1'b1) begin
                        state <= video_pkg::VBLANK_COMMIT;
                    end
                end
                video_pkg::VBLANK_COMMIT: begin
                    // Last line of the frame is kept for rendering row 0
                    if (vcnt == V_LAST - 1'b1) begin
                        state <= video_pkg::VBLANK_PREP;
                    end
                end
                video_pkg::VBLANK_PREP: begin
                    state <= video_pkg::ACTIVE;
                end
                default: begin
                    state <= video_pkg::VBLANK_PREP;
                end
            endcase
        end
    end

    // Render one line ahead: rows 0..7 are built during lines 11, 0..6
    assign render_line  = (state == video_pkg::VBLANK_PREP) ||
                          ((state == video_pkg::ACTIVE) && (vcnt < V_ACTIVE - 1'b1));
    assign render_row   = (vcnt == V_LAST) ? '0 : vcnt + 1'b1;
    assign render_start = render_line && (hcnt == '0);
    assign row_swap     = render_line && line_end;  // Back buffer goes live next line

    assign commit_en   = (state == video_pkg::VBLANK_COMMIT);
    assign vblank      = (state != video_pkg::ACTIVE);
    assign line_active = (state == video_pkg::ACTIVE) && (hcnt < H_ACTIVE);
    assign hsync       = (hcnt >= H_ACTIVE);
    assign hcount      = hcnt;

    // Commit window has to stay clear of every visible line
    a_commit_in_vblank: assert property (@(posedge clk) disable iff (!rst_n)
        commit_en |-> (vcnt >= V_ACTIVE));

endmodule : frame_ctrl

`default_nettype wire

/* source/vram_write_queue.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fpgame_consts.svh"

module vram_write_queue (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               host_wr_valid,
    input  vram_pkg::wr_addr_t host_wr_addr,
    input  vram_pkg::wr_data_t host_wr_data,
    input  logic               commit_en,
    output logic               host_credit,
    vram_wr_if.drain           wr
);

    localparam int DEPTH = `FPGAME_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    vram_pkg::wr_target_t q_target [DEPTH];
    vram_pkg::wr_addr_t   q_addr   [DEPTH];
    vram_pkg::wr_data_t   q_data   [DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [PTR_W:0]       count;
    logic                 push;
    logic                 pop;

    // Address map decode, done once as the write enters
    function automatic vram_pkg::wr_target_t decode_target(input vram_pkg::wr_addr_t addr);
        vram_pkg::wr_target_t tgt;
        if (addr[7:6] == 2'b00) begin
            tgt = vram_pkg::TGT_MAP;
        end else if (addr[7:4] == 4'h4) begin
            tgt = vram_pkg::TGT_PAL;
        end else if (addr == 8'h80) begin
            tgt = vram_pkg::TGT_SCROLL;
        end else begin
            tgt = vram_pkg::TGT_NONE;
        end
        return tgt;
    endfunction

    assign push = host_wr_valid;
    assign pop  = commit_en && (count != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            q_target[wr_ptr] <= decode_target(host_wr_addr);
            q_addr[wr_ptr]   <= host_wr_addr;
            q_data[wr_ptr]   <= host_wr_data;
        end
    end

    // ==============================
    // Pointers and credit return
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            host_credit <= 1'b0;
            wr.valid    <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            host_credit <= pop;     // One credit back per drained entry
            wr.valid    <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            wr.target <= q_target[rd_ptr];
            wr.addr   <= q_addr[rd_ptr];
            wr.data   <= q_data[rd_ptr];
        end
    end

    // A host out of credits would overrun the queue
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        host_wr_valid |-> (count < (PTR_W + 1)'(DEPTH)));

endmodule : vram_write_queue

`default_nettype wire

/* source/row_renderer.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fpgame_consts.svh"

module row_renderer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                render_start,
    input  video_pkg::vcount_t  render_row,
    input  logic                row_swap,
    input  video_pkg::hcount_t  rowbuf_rdaddr,
    output video_pkg::pal_idx_t rowbuf_rddata,
    vram_wr_if.map_sink         wr
);

    localparam int MAP_ENTRIES = `FPGAME_MAP_COLS * `FPGAME_MAP_ROWS;
    localparam int MAP_AW      = $clog2(MAP_ENTRIES);
    localparam int COL_W       = $clog2(`FPGAME_MAP_COLS);
    localparam int PX_W        = $clog2(`FPGAME_H_ACTIVE);
    localparam logic [PX_W-1:0] PX_LAST = PX_W'(`FPGAME_H_ACTIVE - 1);

    video_pkg::pal_idx_t tile_map [MAP_ENTRIES];
    video_pkg::scroll_t  scroll;
    video_pkg::pal_idx_t rowbuf [2][`FPGAME_H_ACTIVE];
    logic                front_sel;     // Buffer being scanned out
    logic                busy;
    logic [PX_W-1:0]     px;
    video_pkg::vcount_t  row_q;
    video_pkg::scroll_t  src_x;         // Map pixel column after scroll
    logic [MAP_AW-1:0]   map_addr;

    // ==============================
    // Tile map and scroll
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < MAP_ENTRIES; i++) begin
                tile_map[i] <= '0;
            end
            scroll <= '0;
        end else if (wr.valid) begin
            if (wr.target == vram_pkg::TGT_MAP) begin
                tile_map[wr.addr[MAP_AW-1:0]] <= wr.data[3:0];
            end
            if (wr.target == vram_pkg::TGT_SCROLL) begin
                scroll <= wr.data[4:0];
            end
        end
    end

    // ==============================
    // Render engine
    // ==============================
    // 5-bit add wraps at the 32 pixel map width
    assign src_x    = video_pkg::scroll_t'(px) + scroll;
    assign map_addr = {row_q[MAP_AW-COL_W:1], src_x[COL_W:1]};  // Tiles are 2x2

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            px        <= '0;
            front_sel <= 1'b0;
        end else begin
            if (render_start) begin
                busy <= 1'b1;
                px   <= '0;
            end else if (busy) begin
                px <= px + 1'b1;
                if (px == PX_LAST) begin
                    busy <= 1'b0;
                end
            end
            if (row_swap) begin
                front_sel <= ~front_sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (render_start) begin
            row_q <= render_row;
        end
        if (busy) begin
            rowbuf[~front_sel][px] <= tile_map[map_addr];  // Fill the back buffer
        end
    end

    assign rowbuf_rddata = rowbuf[front_sel][rowbuf_rdaddr[PX_W-1:0]];

    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        render_start |-> !busy);

    // The row must be complete before it goes to the front
    a_done_before_swap: assert property (@(posedge clk) disable iff (!rst_n)
        row_swap |-> !busy);

endmodule : row_renderer

`default_nettype wire

/* source/pixel_scanout.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fpgame_consts.svh"

module pixel_scanout (
    input  logic                clk,
    input  logic                rst_n,
    input  video_pkg::hcount_t  hcount,
    input  logic                line_active,
    input  logic                hsync,
    input  logic                vblank,
    output video_pkg::hcount_t  rowbuf_rdaddr,
    input  video_pkg::pal_idx_t rowbuf_rddata,
    output logic                vga_de,
    output logic                vga_hs,
    output logic                vga_vs,
    output video_pkg::color_t   vga_rgb,
    vram_wr_if.pal_sink         wr
);

    localparam int PAL_AW = $clog2(`FPGAME_PAL_SIZE);

    video_pkg::color_t palette [`FPGAME_PAL_SIZE];
    video_pkg::color_t pix_color;

    // ==============================
    // Palette
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `FPGAME_PAL_SIZE; i++) begin
                palette[i] <= '0;
            end
        end else if (wr.valid && (wr.target == vram_pkg::TGT_PAL)) begin
            palette[wr.addr[PAL_AW-1:0]] <= wr.data;
        end
    end

    // Front row buffer read is combinational
    assign rowbuf_rdaddr = hcount;
    assign pix_color     = palette[rowbuf_rddata];

    // Outputs lag the counters by one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vga_de  <= 1'b0;
            vga_hs  <= 1'b0;
            vga_vs  <= 1'b0;
            vga_rgb <= '0;
        end else begin
            vga_de  <= line_active;
            vga_hs  <= hsync;
            vga_vs  <= vblank;
            vga_rgb <= line_active ? pix_color : '0;   // Black outside DE
        end
    end

    // Palette changes only land while the screen is blanked
    a_pal_in_vblank: assert property (@(posedge clk) disable iff (!rst_n)
        (wr.valid && (wr.target == vram_pkg::TGT_PAL)) |-> vblank);

endmodule : pixel_scanout

`default_nettype wire

/* source/fpgame.sv */
`timescale 1ns/100ps
`default_nettype none

module fpgame (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               host_wr_valid,
    input  vram_pkg::wr_addr_t host_wr_addr,
    input  vram_pkg::wr_data_t host_wr_data,
    output logic               host_credit,
    output logic               vga_de,
    output logic               vga_hs,
    output logic               vga_vs,
    output video_pkg::color_t  vga_rgb
);

    // ==============================
    // Interconnect
    // ==============================
    logic                commit_en;
    logic                render_start;
    video_pkg::vcount_t  render_row;
    logic                row_swap;
    logic                line_active;
    logic                hsync;
    logic                vblank;
    video_pkg::hcount_t  hcount;
    video_pkg::hcount_t  rowbuf_rdaddr;
    video_pkg::pal_idx_t rowbuf_rddata;

    vram_wr_if wr_bus ();   // Committed writes to map, scroll and palette

    // ==============================
    // Submodules
    // ==============================
    frame_ctrl u_frame_ctrl (
        .clk,
        .rst_n,
        .commit_en,
        .render_start,
        .render_row,
        .row_swap,
        .line_active,
        .hsync,
        .vblank,
        .hcount
    );

    vram_write_queue u_wr_queue (
        .clk,
        .rst_n,
        .host_wr_valid,
        .host_wr_addr,
        .host_wr_data,
        .commit_en,
        .host_credit,
        .wr(wr_bus.drain)
    );

    row_renderer u_renderer (
        .clk,
        .rst_n,
        .render_start,
        .render_row,
        .row_swap,
        .rowbuf_rdaddr,
        .rowbuf_rddata,
        .wr(wr_bus.map_sink)
    );

    pixel_scanout u_scanout (
        .clk,
        .rst_n,
        .hcount,
        .line_active,
        .hsync,
        .vblank,
        .rowbuf_rdaddr,
        .rowbuf_rddata,
        .vga_de,
        .vga_hs,
        .vga_vs,
        .vga_rgb,
        .wr(wr_bus.pal_sink)
    );

endmodule : fpgame

`default_nettype wire

/* tb/tb_clkgen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule : tb_clkgen

`default_nettype wire

/* tb/fpgame_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fpgame_consts.svh"

module fpgame_tb;

    localparam int H_TOTAL    = `FPGAME_H_TOTAL;
    localparam int H_ACTIVE   = `FPGAME_H_ACTIVE;
    localparam int V_TOTAL    = `FPGAME_V_TOTAL;
    localparam int V_ACTIVE   = `FPGAME_V_ACTIVE;
    localparam int MAP_COLS   = `FPGAME_MAP_COLS;
    localparam int MAP_PIX    = 2 * `FPGAME_MAP_COLS;   // Map width in pixels
    localparam int DEPTH      = `FPGAME_QUEUE_DEPTH;
    localparam int RUN_FRAMES = 12;
    localparam int TIMEOUT    = (RUN_FRAMES + 2) * H_TOTAL * V_TOTAL;

    logic               clk;
    logic               rst_n         = 1'b0;
    logic               host_wr_valid = 1'b0;
    vram_pkg::wr_addr_t host_wr_addr  = '0;
    vram_pkg::wr_data_t host_wr_data  = '0;
    logic               host_credit;
    logic               vga_de;
    logic               vga_hs;
    logic               vga_vs;
    video_pkg::color_t  vga_rgb;

    // Mirror of committed video memory
    logic [3:0]         map_m [MAP_COLS * `FPGAME_MAP_ROWS];
    video_pkg::color_t  pal_m [`FPGAME_PAL_SIZE];
    int                 scroll_m;
    vram_pkg::wr_addr_t pend_addr [$];     // Sent, not yet visible
    vram_pkg::wr_data_t pend_data [$];

    int                 h_pos;
    int                 v_pos;
    int                 out_h;
    int                 out_v;
    int                 disp_frame = -1;   // Frame shown on the outputs
    logic               exp_de  = 1'b0;
    logic               exp_hs  = 1'b0;
    logic               exp_vs  = 1'b0;
    video_pkg::color_t  exp_rgb = '0;
    logic               prev_vs = 1'b0;

    int credits        = DEPTH;
    int sent           = 0;
    int returned       = 0;
    logic chk_frame    = 1'b0;             // One cycle at each frame start
    int chk_credits    = DEPTH;
    int chk_sent       = 0;
    int chk_ret        = 0;
    int frame_starts   = 0;
    int mismatches     = 0;
    int other_errors   = 0;
    int pixels_checked = 0;
    int cycle_count    = 0;

    tb_clkgen u_clkgen (.clk);

    fpgame dut0 (
        .clk,
        .rst_n,
        .host_wr_valid,
        .host_wr_addr,
        .host_wr_data,
        .host_credit,
        .vga_de,
        .vga_hs,
        .vga_vs,
        .vga_rgb
    );

    task automatic report_mismatch(input string name, input logic [23:0] expected,
                                   input logic [23:0] actual);
        mismatches++;
        $display("MISMATCH %s: expected 0x%0h, got 0x%0h (frame %0d, line %0d, cycle %0d)",
                 name, expected, actual, disp_frame, out_v, out_h);
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("ERROR: %s", what);
    endtask

    // Host address map: tile map, palette, scroll, the rest dropped
    task automatic apply_write(input vram_pkg::wr_addr_t a, input vram_pkg::wr_data_t d);
        if (a < 8'h40) begin
            map_m[a[5:0]] = d[3:0];
        end else if (a < 8'h50) begin
            pal_m[a[3:0]] = d;
        end else if (a == 8'h80) begin
            scroll_m = int'(d[4:0]);
        end
    endtask

    function automatic vram_pkg::wr_addr_t pick_addr();
        int                 kind;
        vram_pkg::wr_addr_t addr;
        kind = $urandom_range(0, 15);
        if (kind < 8) begin
            addr = vram_pkg::wr_addr_t'($urandom_range(0, 63));
        end else if (kind < 12) begin
            addr = 8'h40 + vram_pkg::wr_addr_t'($urandom_range(0, 15));
        end else if (kind < 14) begin
            addr = 8'h80;
        end else begin
            addr = 8'h81 + vram_pkg::wr_addr_t'($urandom_range(0, 126));  // Unmapped
        end
        return addr;
    endfunction

    // Tiles are 2x2 pixels and the map wraps at its pixel width
    function automatic video_pkg::color_t pixel_color(input int x, input int y);
        int         col;
        logic [5:0] idx;
        col = ((x + scroll_m) % MAP_PIX) / 2;
        idx = 6'((y / 2) * MAP_COLS + col);
        return pal_m[map_m[idx]];
    endfunction

    // ==============================
    // Display model and host writes
    // ==============================
    always @(posedge clk) begin : model_and_drive
        logic               issue;
        vram_pkg::wr_addr_t addr;
        vram_pkg::wr_data_t data;
        if (!rst_n) begin
            h_pos   = 0;
            v_pos   = V_TOTAL - 1;      // Line before row 0
            disp_frame = -1;
            exp_de  = 1'b0;
            exp_hs  = 1'b0;
            exp_vs  = 1'b0;
            exp_rgb = '0;
            foreach (map_m[i]) map_m[i] = '0;
            foreach (pal_m[i]) pal_m[i] = '0;
            scroll_m  = 0;
            credits   = DEPTH;
            prev_vs   = 1'b0;
            chk_frame = 1'b0;
            host_wr_valid <= 1'b0;
        end else begin
            // Outputs after this edge show the position before it
            if ((h_pos == 0) && (v_pos == 0)) begin
                disp_frame++;
            end
            out_h   = h_pos;
            out_v   = v_pos;
            exp_de  = (v_pos < V_ACTIVE) && (h_pos < H_ACTIVE);
            exp_hs  = (h_pos >= H_ACTIVE);
            exp_vs  = (v_pos >= V_ACTIVE);
            exp_rgb = exp_de ? pixel_color(h_pos, v_pos) : '0;
            if (exp_de) begin
                pixels_checked++;
            end
            if (h_pos == H_TOTAL - 1) begin
                h_pos = 0;
                v_pos = (v_pos == V_TOTAL - 1) ? 0 : v_pos + 1;
            end else begin
                h_pos++;
            end

            chk_frame = 1'b0;
            if (vga_vs && !prev_vs) begin
                while (pend_addr.size() > 0) begin
                    apply_write(pend_addr.pop_front(), pend_data.pop_front());
                end
            end
            if (!vga_vs && prev_vs) begin
                chk_frame   = 1'b1;
                chk_credits = credits;
                chk_sent    = sent;
                chk_ret     = returned;
                sent        = 0;
                returned    = 0;
                frame_starts++;
            end
            prev_vs = vga_vs;

            if (host_credit) begin
                credits++;
                returned++;
            end

            // Odd frames get a back-to-back burst, even frames spread out
            issue = (frame_starts > 0) && !vga_vs && (credits > 0);
            if (issue && (frame_starts % 2 == 0)) begin
                issue = ($urandom_range(0, 5) == 0);
            end
            if (issue) begin
                addr = pick_addr();
                data = vram_pkg::wr_data_t'($urandom);
                host_wr_addr <= addr;
                host_wr_data <= data;
                pend_addr.push_back(addr);
                pend_data.push_back(data);
                credits--;
                sent++;
            end
            host_wr_valid <= issue;
        end
    end

    // ==============================
    // Checks
    // ==============================
    a_de: assert property (@(negedge clk) vga_de == exp_de)
        else report_mismatch("vga_de", 24'(exp_de), 24'(vga_de));
    a_hs: assert property (@(negedge clk) vga_hs == exp_hs)
        else report_mismatch("vga_hs", 24'(exp_hs), 24'(vga_hs));
    a_vs: assert property (@(negedge clk) vga_vs == exp_vs)
        else report_mismatch("vga_vs", 24'(exp_vs), 24'(vga_vs));
    a_rgb: assert property (@(negedge clk) vga_rgb == exp_rgb)
        else report_mismatch("vga_rgb", exp_rgb, vga_rgb);

    // Frame 0 comes from the reset contents
    a_frame0_black: assert property (@(negedge clk)
        ((disp_frame == 0) && vga_de) |-> (vga_rgb == '0))
        else report_mismatch("vga_rgb", '0, vga_rgb);

    a_reset_quiet: assert property (@(negedge clk)
        !rst_n |-> !(vga_de || vga_hs || vga_vs || host_credit))
        else report_failure("video or credit output active during reset");

    a_credit_in_vblank: assert property (@(negedge clk) host_credit |-> vga_vs)
        else report_failure("credit returned outside vertical blank");
    a_credit_range: assert property (@(negedge clk) credits <= DEPTH)
        else report_failure("more credits returned than the queue holds");
    a_credits_full: assert property (@(negedge clk) chk_frame |-> (chk_credits == DEPTH))
        else report_failure($sformatf("frame started with %0d credits", chk_credits));
    a_burst_returned: assert property (@(negedge clk) chk_frame |-> (chk_ret == chk_sent))
        else report_failure($sformatf("%0d writes returned %0d credits", chk_sent, chk_ret));

    // ==============================
    // Run control
    // ==============================
    initial begin
        void'($urandom(32'h4ee6));
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        wait (frame_starts == RUN_FRAMES + 1);
        repeat (2) @(posedge clk);
        $display("Errors: %0d mismatches, %0d other, over %0d pixels in %0d frames",
                 mismatches, other_errors, pixels_checked, RUN_FRAMES);
        if ((mismatches == 0) && (other_errors == 0)) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("ERROR: run did not finish within %0d cycles, %0d frames started",
                     TIMEOUT, frame_starts);
            $display("Errors: %0d mismatches, %0d other", mismatches, other_errors + 1);
            $display("Simulation FAILED");
            $finish;
        end
    end

endmodule : fpgame_tb

`default_nettype wire

/* vlog.f */
+incdir+source
source/video_pkg.sv
source/vram_pkg.sv
source/vram_wr_if.sv
source/frame_ctrl.sv
source/vram_write_queue.sv
source/row_renderer.sv
source/pixel_scanout.sv
source/fpgame.sv
tb/tb_clkgen.sv
tb/fpgame_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the fpgame testbench with Verilator, run it, and pass only on the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module fpgame_tb -f vlog.f -o fpgame_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/fpgame_sim | tee /dev/stderr | grep "Simulation PASSED" > /dev/null \
    && exit 0 \
    || exit 1
